/* design/refill_defines.svh */
`ifndef REFILL_DEFINES_SVH
`define REFILL_DEFINES_SVH

// byte address width on the memory bus and at both refill ports
`define REFILL_ADDR_BITS 32

// one data beat on the burst memory bus
`define REFILL_BEAT_BITS 64

// one cache line as seen by the refill ports
`define REFILL_LINE_BITS 256

// beats that make up one line, beat 0 is the low 64 bits
`define REFILL_BEATS 4

// counter width able to index every beat of a line
`define REFILL_BEAT_IDX_BITS 2

`endif

/* design/refill_pkg.sv */
`include "refill_defines.svh"

package refill_pkg;

    // byte address, line aligned at the refill ports
    typedef logic [`REFILL_ADDR_BITS-1:0] addr_t;

    // single burst beat
    typedef logic [`REFILL_BEAT_BITS-1:0] beat_t;

    // full cache line
    typedef logic [`REFILL_LINE_BITS-1:0] line_t;

    // which refill port currently owns the memory
    typedef enum logic [1:0] {
        SRC_NONE  = 2'd0,   // arbiter idle
        SRC_INSTR = 2'd1,   // instruction cache refill
        SRC_DATA  = 2'd2    // data cache refill or writeback
    } req_src_e;

endpackage : refill_pkg

/* design/burst_if.sv */
`timescale 1ns/100ps

// one granted line transfer between the fill arbiter and the cacheline adapter
interface burst_if;
    import refill_pkg::*;

    addr_t addr;    // line address of the owner
    logic  read;    // line read, held until done
    logic  write;   // line writeback, held until done
    line_t wline;   // dirty line to split into beats
    line_t rline;   // assembled line, valid with done
    logic  done;    // one cycle end of transfer

    modport arbiter (
        output addr,
        output read,
        output write,
        output wline,
        input  rline,
        input  done
    );

    modport adapter (
        input  addr,
        input  read,
        input  write,
        input  wline,
        output rline,
        output done
    );

endinterface : burst_if

/* design/fill_arbiter.sv */
`timescale 1ns/100ps

module fill_arbiter (
    input  logic              clk,
    input  logic              rst,

    // instruction cache refill port
    input  refill_pkg::addr_t ifill_addr_i,
    input  logic              ifill_read_i,
    output refill_pkg::line_t ifill_line_o,
    output logic              ifill_resp_o,

    // data cache refill port
    input  refill_pkg::addr_t dfill_addr_i,
    input  logic              dfill_read_i,
    input  logic              dfill_write_i,
    input  refill_pkg::line_t dfill_wline_i,
    output refill_pkg::line_t dfill_line_o,
    output logic              dfill_resp_o,

    burst_if.arbiter          bus
);
    import refill_pkg::*;

    req_src_e owner_q;      // current grant holder
    req_src_e owner_d;
    logic     ifill_req;
    logic     dfill_req;

    assign ifill_req = ifill_read_i;
    assign dfill_req = dfill_read_i | dfill_write_i;

    // grant only from idle with data port first
    always_comb begin
        owner_d = owner_q;
        case (owner_q)
            SRC_NONE: begin
                if (dfill_req) begin
                    owner_d = SRC_DATA;
                end else if (ifill_req) begin
                    owner_d = SRC_INSTR;
                end
            end
            default: begin
                if (bus.done) begin
                    owner_d = SRC_NONE;   // back to idle after done
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner_q <= SRC_NONE;
        end else begin
            owner_q <= owner_d;
        end
    end

    // forward the owner's request to the adapter
    always_comb begin
        bus.addr  = '0;
        bus.read  = 1'b0;
        bus.write = 1'b0;
        bus.wline = '0;
        case (owner_q)
            SRC_INSTR: begin
                bus.addr = ifill_addr_i;
                bus.read = ifill_read_i;
            end
            SRC_DATA: begin
                bus.addr  = dfill_addr_i;
                bus.read  = dfill_read_i;
                bus.write = dfill_write_i;
                bus.wline = dfill_wline_i;
            end
            default: ;
        endcase
    end

    // response reaches only the owner in the cycle of done
    assign ifill_resp_o = (owner_q == SRC_INSTR) && bus.done;
    assign dfill_resp_o = (owner_q == SRC_DATA) && bus.done;
    assign ifill_line_o = (owner_q == SRC_INSTR) ? bus.rline : '0;
    assign dfill_line_o = (owner_q == SRC_DATA) ? bus.rline : '0;

    // every adapter done answers exactly one port
    a_single_resp: assert property (
        @(posedge clk) disable iff (rst)
        bus.done |-> (ifill_resp_o ^ dfill_resp_o)
    ) else $error("adapter done not answered by one port, owner %s", owner_q.name());

endmodule : fill_arbiter

/* design/cacheline_adapter.sv */
`timescale 1ns/100ps
`include "refill_defines.svh"

module cacheline_adapter (
    input  logic              clk,
    input  logic              rst,

    burst_if.adapter          bus,

    // burst memory side
    output refill_pkg::addr_t bmem_addr_o,
    output logic              bmem_read_o,
    output logic              bmem_write_o,
    output refill_pkg::beat_t bmem_wdata_o,
    input  logic              bmem_ready_i,
    input  refill_pkg::addr_t bmem_raddr_i,
    input  refill_pkg::beat_t bmem_rdata_i,
    input  logic              bmem_rvalid_i
);
    import refill_pkg::*;

    localparam int IDX_BITS = `REFILL_BEAT_IDX_BITS;
    localparam int BEAT_BITS = `REFILL_BEAT_BITS;
    localparam logic [IDX_BITS-1:0] LAST_BEAT = IDX_BITS'(`REFILL_BEATS - 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ISSUE_RD,    // read request until accepted
        ST_COLLECT,     // wait for the four read beats
        ST_WRITE,       // push the four write beats
        ST_DONE         // one cycle done to the arbiter
    } state_e;

    state_e              state_q;
    state_e              state_d;
    logic [IDX_BITS-1:0] beat_q;    // beat slot for both directions
    addr_t               addr_q;    // outstanding line address
    line_t               line_q;    // read line under assembly

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (bus.write) begin
                    state_d = ST_WRITE;
                end else if (bus.read) begin
                    state_d = ST_ISSUE_RD;
                end
            end
            ST_ISSUE_RD: begin
                if (bmem_ready_i) begin
                    state_d = ST_COLLECT;
                end
            end
            ST_COLLECT: begin
                if (bmem_rvalid_i && beat_q == LAST_BEAT) begin
                    state_d = ST_DONE;
                end
            end
            ST_WRITE: begin
                if (bmem_ready_i && beat_q == LAST_BEAT) begin
                    state_d = ST_DONE;
                end
            end
            default: state_d = ST_IDLE;   // done lasts one cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            case (state_q)
                ST_IDLE: beat_q <= '0;
                ST_COLLECT: begin
                    if (bmem_rvalid_i) begin
                        beat_q <= beat_q + 1'b1;
                    end
                end
                ST_WRITE: begin
                    if (bmem_ready_i) begin
                        beat_q <= beat_q + 1'b1;    // advance only when accepted
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && (bus.read || bus.write)) begin
            addr_q <= bus.addr;
        end
        if (state_q == ST_COLLECT && bmem_rvalid_i) begin
            line_q[beat_q*BEAT_BITS +: BEAT_BITS] <= bmem_rdata_i;  // beat 0 lands low
        end
    end

    assign bmem_addr_o  = addr_q;
    assign bmem_read_o  = (state_q == ST_ISSUE_RD);
    assign bmem_write_o = (state_q == ST_WRITE);
    assign bmem_wdata_o = bus.wline[beat_q*BEAT_BITS +: BEAT_BITS];

    assign bus.rline = line_q;
    assign bus.done  = (state_q == ST_DONE);

    // memory may only return data for a request this adapter issued
    a_rvalid_in_collect: assert property (
        @(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> state_q == ST_COLLECT
    ) else $error("read beat arrived in state %s", state_q.name());

    a_raddr_match: assert property (
        @(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> bmem_raddr_i == addr_q
    ) else $error("read beat address %h, expected %h", bmem_raddr_i, addr_q);

endmodule : cacheline_adapter

/* design/mem_refill_top.sv */
`timescale 1ns/100ps

module mem_refill_top (
    input  logic              clk,
    input  logic              rst,

    // instruction cache refill port
    input  refill_pkg::addr_t ifill_addr_i,
    input  logic              ifill_read_i,
    output refill_pkg::line_t ifill_line_o,
    output logic              ifill_resp_o,

    // data cache refill port
    input  refill_pkg::addr_t dfill_addr_i,
    input  logic              dfill_read_i,
    input  logic              dfill_write_i,
    input  refill_pkg::line_t dfill_wline_i,
    output refill_pkg::line_t dfill_line_o,
    output logic              dfill_resp_o,

    // burst memory
    output refill_pkg::addr_t bmem_addr_o,
    output logic              bmem_read_o,
    output logic              bmem_write_o,
    output refill_pkg::beat_t bmem_wdata_o,
    input  logic              bmem_ready_i,
    input  refill_pkg::addr_t bmem_raddr_i,
    input  refill_pkg::beat_t bmem_rdata_i,
    input  logic              bmem_rvalid_i
);

    burst_if bus_if ();   // granted line transfer

    fill_arbiter u_fill_arbiter (
        .clk           (clk),
        .rst           (rst),
        .ifill_addr_i  (ifill_addr_i),
        .ifill_read_i  (ifill_read_i),
        .ifill_line_o  (ifill_line_o),
        .ifill_resp_o  (ifill_resp_o),
        .dfill_addr_i  (dfill_addr_i),
        .dfill_read_i  (dfill_read_i),
        .dfill_write_i (dfill_write_i),
        .dfill_wline_i (dfill_wline_i),
        .dfill_line_o  (dfill_line_o),
        .dfill_resp_o  (dfill_resp_o),
        .bus           (bus_if.arbiter)
    );

    cacheline_adapter u_cacheline_adapter (
        .clk           (clk),
        .rst           (rst),
        .bus           (bus_if.adapter),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_write_o  (bmem_write_o),
        .bmem_wdata_o  (bmem_wdata_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

endmodule : mem_refill_top

/* dv/burst_mem_model.sv */
`timescale 1ns/100ps
`include "refill_defines.svh"

module burst_mem_model #(
    parameter int unsigned SEED = 1
) (
    input  logic              clk,
    input  logic              rst,
    input  refill_pkg::addr_t bmem_addr_i,
    input  logic              bmem_read_i,
    input  logic              bmem_write_i,
    input  refill_pkg::beat_t bmem_wdata_i,
    output logic              bmem_ready_o,
    output refill_pkg::addr_t bmem_raddr_o,
    output refill_pkg::beat_t bmem_rdata_o,
    output logic              bmem_rvalid_o
);
    import refill_pkg::*;

    localparam int IDX_BITS = `REFILL_BEAT_IDX_BITS;
    localparam logic [IDX_BITS-1:0] LAST_BEAT = IDX_BITS'(`REFILL_BEATS - 1);
    localparam logic [31:0] FILL_KEY = 32'h5A5A_0000;

    logic [31:0]         mem [addr_t];  // sparse, written words only
    logic                rd_busy;
    logic [1:0]          rd_wait;       // cycles left before the first beat
    logic [IDX_BITS-1:0] rd_beat;
    logic [IDX_BITS-1:0] wr_beat;
    addr_t               rd_addr;

    function automatic logic [31:0] read_word(input addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ FILL_KEY;    // untouched word
    endfunction

    function automatic beat_t read_beat(input addr_t a);
        return {read_word(a + 32'd4), read_word(a)};   // low word at the beat address
    endfunction

    // ready drops on about one cycle in four
    initial begin
        void'($urandom(SEED));
        bmem_ready_o <= 1'b0;
        forever begin
            @(posedge clk);
            bmem_ready_o <= ($urandom % 4) != 0;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            rd_busy       <= 1'b0;
            rd_wait       <= '0;
            rd_beat       <= '0;
            wr_beat       <= '0;
            rd_addr       <= '0;
            bmem_rvalid_o <= 1'b0;
            bmem_raddr_o  <= '0;
            bmem_rdata_o  <= '0;
        end else begin
            bmem_rvalid_o <= 1'b0;
            if (rd_busy) begin
                if (rd_wait != 2'd0) begin
                    rd_wait <= rd_wait - 2'd1;
                end else begin
                    bmem_rvalid_o <= 1'b1;
                    bmem_raddr_o  <= rd_addr;   // echo of the request address
                    bmem_rdata_o  <= read_beat(rd_addr + addr_t'({rd_beat, 3'b000}));
                    rd_beat       <= rd_beat + 1'b1;
                    if (rd_beat == LAST_BEAT) begin
                        rd_busy <= 1'b0;
                    end
                end
            end else if (bmem_read_i && bmem_ready_o) begin
                rd_busy <= 1'b1;
                rd_addr <= bmem_addr_i;
                rd_wait <= 2'd2;    // first beat three cycles after acceptance
                rd_beat <= '0;
            end
            if (bmem_write_i && bmem_ready_o) begin
                mem[bmem_addr_i + addr_t'({wr_beat, 3'b000})]         = bmem_wdata_i[31:0];
                mem[bmem_addr_i + addr_t'({wr_beat, 3'b000}) + 32'd4] = bmem_wdata_i[63:32];
                wr_beat <= wr_beat + 1'b1;  // wraps after the last beat
            end
        end
    end

endmodule : burst_mem_model

/* dv/tb_mem_refill.sv */
`timescale 1ns/100ps
`include "refill_defines.svh"

module tb_mem_refill;
    import refill_pkg::*;

    localparam int unsigned SEED         = 26553;
    localparam int          RESET_CYCLES = 4;
    localparam int          NUM_ROWS     = 12;
    localparam int          WORDS        = `REFILL_LINE_BITS / 32;
    localparam logic [31:0] FILL_KEY     = 32'h5A5A_0000;

    typedef enum logic [1:0] {
        OP_IFETCH,
        OP_DREAD,
        OP_DWRITE,
        OP_BOTH     // instruction at addr, data at the next line
    } op_e;

    typedef struct packed {
        op_e         op;
        addr_t       addr;
        logic [31:0] seed;  // used by writes
    } row_t;

    row_t rows [NUM_ROWS] = '{
        '{OP_IFETCH, 32'h0000_1000, 32'h0},
        '{OP_DREAD,  32'h0000_2040, 32'h0},
        '{OP_DWRITE, 32'h0000_3000, 32'h1111_0000},
        '{OP_DREAD,  32'h0000_3000, 32'h0},
        '{OP_IFETCH, 32'h0000_3000, 32'h0},
        '{OP_BOTH,   32'h0000_4000, 32'h0},
        '{OP_DWRITE, 32'h0000_5000, 32'hCAFE_0100},
        '{OP_BOTH,   32'h0000_4FE0, 32'h0},
        '{OP_DWRITE, 32'h0000_3000, 32'hBEEF_0000},
        '{OP_IFETCH, 32'h0000_3000, 32'h0},
        '{OP_DREAD,  32'hFFFF_FFE0, 32'h0},
        '{OP_BOTH,   32'h0000_0000, 32'h0}
    };

    logic  clk;
    logic  rst;
    addr_t ifill_addr;
    logic  ifill_read;
    line_t ifill_line;
    logic  ifill_resp;
    addr_t dfill_addr;
    logic  dfill_read;
    logic  dfill_write;
    line_t dfill_wline;
    line_t dfill_line;
    logic  dfill_resp;
    addr_t bmem_addr;
    logic  bmem_read;
    logic  bmem_write;
    beat_t bmem_wdata;
    logic  bmem_ready;
    addr_t bmem_raddr;
    beat_t bmem_rdata;
    logic  bmem_rvalid;

    line_t written [addr_t];    // lines the data port has stored
    int    errors = 0;
    int    checks = 0;
    int    iresp_seen = 0;
    int    dresp_seen = 0;
    int    iresp_expected = 0;
    int    dresp_expected = 0;

    mem_refill_top u_mem_refill_top (
        .clk           (clk),
        .rst           (rst),
        .ifill_addr_i  (ifill_addr),
        .ifill_read_i  (ifill_read),
        .ifill_line_o  (ifill_line),
        .ifill_resp_o  (ifill_resp),
        .dfill_addr_i  (dfill_addr),
        .dfill_read_i  (dfill_read),
        .dfill_write_i (dfill_write),
        .dfill_wline_i (dfill_wline),
        .dfill_line_o  (dfill_line),
        .dfill_resp_o  (dfill_resp),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_write_o  (bmem_write),
        .bmem_wdata_o  (bmem_wdata),
        .bmem_ready_i  (bmem_ready),
        .bmem_raddr_i  (bmem_raddr),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid)
    );

    burst_mem_model #(.SEED(SEED)) u_burst_mem_model (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_i   (bmem_addr),
        .bmem_read_i   (bmem_read),
        .bmem_write_i  (bmem_write),
        .bmem_wdata_i  (bmem_wdata),
        .bmem_ready_o  (bmem_ready),
        .bmem_raddr_o  (bmem_raddr),
        .bmem_rdata_o  (bmem_rdata),
        .bmem_rvalid_o (bmem_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic line_t rule_line(input addr_t addr);
        line_t line;
        for (int k = 0; k < WORDS; k++) begin
            line[k*32 +: 32] = (addr + 32'(4 * k)) ^ FILL_KEY;
        end
        return line;
    endfunction

    function automatic line_t seeded_line(input logic [31:0] seed);
        line_t line;
        for (int k = 0; k < WORDS; k++) begin
            line[k*32 +: 32] = seed + 32'(k);   // word 0 in the low bits
        end
        return line;
    endfunction

    function automatic line_t expected_line(input addr_t addr);
        if (written.exists(addr)) begin
            return written[addr];
        end
        return rule_line(addr);
    endfunction

    task automatic check_line(input string port, input addr_t addr, input line_t got);
        line_t exp;
        exp = expected_line(addr);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH at %0t: %s read of %h returned %h, expected %h",
                     $time, port, addr, got, exp);
        end
    endtask

    task automatic check_idle_outputs();
        checks++;
        assert (!bmem_read && !bmem_write && !ifill_resp && !dfill_resp) else begin
            errors++;
            $display("MISMATCH at %0t: after reset read %b write %b iresp %b dresp %b",
                     $time, bmem_read, bmem_write, ifill_resp, dfill_resp);
        end
    endtask

    task automatic check_resp_counts(input int row);
        checks++;
        assert (iresp_seen == iresp_expected && dresp_seen == dresp_expected) else begin
            errors++;
            $display("MISMATCH at %0t: row %0d resp pulses ifill %0d/%0d dfill %0d/%0d",
                     $time, row, iresp_seen, iresp_expected, dresp_seen, dresp_expected);
        end
    endtask

    // one port, request held until its resp
    task automatic single_transfer(input op_e op, input addr_t addr, input logic [31:0] seed);
        line_t got;
        logic  seen;
        @(posedge clk);
        case (op)
            OP_IFETCH: begin
                ifill_addr <= addr;
                ifill_read <= 1'b1;
            end
            OP_DREAD: begin
                dfill_addr <= addr;
                dfill_read <= 1'b1;
            end
            default: begin
                dfill_addr  <= addr;
                dfill_wline <= seeded_line(seed);
                dfill_write <= 1'b1;
            end
        endcase
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (op == OP_IFETCH) begin
                seen = ifill_resp;
                got  = ifill_line;
            end else begin
                seen = dfill_resp;
                got  = dfill_line;
            end
        end
        @(posedge clk);
        ifill_read  <= 1'b0;
        dfill_read  <= 1'b0;
        dfill_write <= 1'b0;
        if (op == OP_DWRITE) begin
            written[addr] = seeded_line(seed);
        end else begin
            check_line(op == OP_IFETCH ? "ifetch" : "dread", addr, got);
        end
    endtask

    // both ports raise read in the same cycle, data must answer first
    task automatic run_both(input addr_t iaddr, input addr_t daddr);
        logic i_done;
        logic d_done;
        @(posedge clk);
        ifill_addr <= iaddr;
        ifill_read <= 1'b1;
        dfill_addr <= daddr;
        dfill_read <= 1'b1;
        i_done = 1'b0;
        d_done = 1'b0;
        while (!(i_done && d_done)) begin
            @(negedge clk);
            if (ifill_resp) begin
                checks++;
                assert (d_done && !dfill_resp) else begin
                    errors++;
                    $display("MISMATCH at %0t: ifill resp not after dfill resp", $time);
                end
                check_line("ifetch", iaddr, ifill_line);
                i_done = 1'b1;
            end
            if (dfill_resp) begin
                check_line("dread", daddr, dfill_line);
                d_done = 1'b1;
            end
            @(posedge clk);
            if (i_done) begin
                ifill_read <= 1'b0;
            end
            if (d_done) begin
                dfill_read <= 1'b0;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (ifill_resp) begin
                iresp_seen++;
            end
            if (dfill_resp) begin
                dresp_seen++;
            end
        end
    end

    initial begin
        rst         <= 1'b1;
        ifill_addr  <= '0;
        ifill_read  <= 1'b0;
        dfill_addr  <= '0;
        dfill_read  <= 1'b0;
        dfill_write <= 1'b0;
        dfill_wline <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_idle_outputs();
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].op == OP_BOTH) begin
                iresp_expected++;
                dresp_expected++;
                run_both(rows[r].addr, rows[r].addr + 32'h20);
            end else begin
                if (rows[r].op == OP_IFETCH) begin
                    iresp_expected++;
                end else begin
                    dresp_expected++;
                end
                single_transfer(rows[r].op, rows[r].addr, rows[r].seed);
            end
            @(negedge clk);     // a stretched resp would be counted here
            @(posedge clk);
            check_resp_counts(r);
        end
        repeat (2) @(posedge clk);
        $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // generous bound of 200 cycles per row
    initial begin
        repeat (RESET_CYCLES + NUM_ROWS * 200) @(posedge clk);
        $display("timeout: rows did not finish within %0d cycles, errors %0d",
                 RESET_CYCLES + NUM_ROWS * 200, errors);
        $display("Testbench failed");
        $finish;
    end

endmodule : tb_mem_refill

/* all.f */
+incdir+design
design/refill_pkg.sv
design/burst_if.sv
design/fill_arbiter.sv
design/cacheline_adapter.sv
design/mem_refill_top.sv
dv/burst_mem_model.sv
dv/tb_mem_refill.sv

/* Makefile */
# Verilator build and run for the refill testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_mem_refill
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "Testbench passed" $(LOG); then \
		echo "result: pass, log in $(LOG)"; \
	else \
		echo "result: fail, log in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
